// ==== rvb_core.f ====
+incdir+verilog
verilog/rvb_pkg.sv
verilog/rvb_clk_gating.sv
verilog/rvb_fetch_unit.sv
verilog/rvb_instr_queue.sv
verilog/rvb_exec_unit.sv
verilog/rvb_core.sv
testbench/tb_imem_model.sv
testbench/tb_rvb_core.sv

// ==== testbench/tb_imem_model.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rvb_config.svh"

// instruction memory behind a held request and a one cycle acknowledge.
// every request is answered after a pseudo-random number of cycles, and the
// contents follow a fixed rule instead of a loaded image.
module tb_imem_model #(
    parameter rvb_pkg::addr_t reset_pc     = `RVB_RESET_PC,
    parameter int             wfi_index    = 10,
    parameter int             ebreak_index = 30,
    parameter int unsigned    seed         = 30904,
    parameter int             lat_min      = 1,
    parameter int             lat_max      = 4
) (
    input  logic           CLK,
    input  logic           arst_n,
    input  logic           imem_req,
    input  rvb_pkg::addr_t imem_addr,
    output logic           imem_ack,
    output rvb_pkg::insn_t imem_rdata
);
    import rvb_pkg::*;

    localparam insn_t insn_nop = 32'h0000_0013; // addi x0, x0, 0.

    int unsigned lcg_state; // generator state, stepped once per request.
    logic        busy;      // a request is being counted down.
    int          remain;    // cycles left until the acknowledge.
    logic        ack_next;
    insn_t       data_next;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345; // wraps modulo 2**32.
    endfunction

    // the word index is taken relative to the reset vector.
    function automatic insn_t word_at(input addr_t addr);
        addr_t index;
        index = (addr - reset_pc) >> 2;
        if (index == addr_t'(wfi_index)) begin
            return `RVB_INSN_WFI;
        end
        if (index == addr_t'(ebreak_index)) begin
            return `RVB_INSN_EBREAK;
        end
        return insn_nop;
    endfunction

    initial begin
        lcg_state  = seed;
        busy       = 1'b0;
        remain     = 0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
    end

    // the bus is sampled on the edge and answered 1 ns later.
    always @(posedge CLK) begin
        ack_next  = 1'b0;
        data_next = '0;
        if (!arst_n) begin
            busy = 1'b0;
        end else if (imem_req && !imem_ack) begin
            if (!busy) begin
                busy      = 1'b1; // a new request, draw its latency.
                lcg_state = lcg_next(lcg_state);
                remain    = lat_min + int'((lcg_state >> 16) % (lat_max - lat_min + 1));
            end
            remain = remain - 1;
            if (remain == 0) begin
                busy      = 1'b0;
                ack_next  = 1'b1;
                data_next = word_at(imem_addr);
            end
        end
        #1;
        imem_ack   = ack_next; // high for exactly one cycle.
        imem_rdata = data_next;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_rvb_core.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rvb_config.svh"

module tb_rvb_core;
    import rvb_pkg::*;

    localparam addr_t reset_pc     = `RVB_RESET_PC;
    localparam int    depth        = `RVB_QUEUE_DEPTH;
    localparam int    wfi_index    = 10;
    localparam int    ebreak_index = 30;
    localparam int    sleep_cycles = 40;  // cycles from the wfi pulse to the interrupt.
    localparam int    max_cycles   = 400; // 31 words at up to 5 cycles, the sleep, margin.
    localparam int    num_tests    = 6;

    logic   CLK;
    logic   arst_n;
    logic   soft_irq;
    logic   imem_ack;
    insn_t  imem_rdata;
    logic   imem_req;
    addr_t  imem_addr;
    logic   wfi;
    logic   halt;
    count_t instret;

    int     cycle_count;
    int     fail_count [num_tests];
    int     passed;
    int     failed;
    longint ack_count;    // words delivered by the memory so far.
    longint in_queue;     // words fetched but not yet retired.
    logic   wait_pending; // a request was open without an ack at the last edge.
    addr_t  wait_addr;
    logic   req_prev;
    logic   halt_seen;
    logic   sleep_watch;  // set while the core should be asleep.
    count_t sleep_base;

    rvb_core i_dut (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .soft_irq  (soft_irq),
        .imem_ack  (imem_ack),
        .imem_rdata(imem_rdata),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .wfi       (wfi),
        .halt      (halt),
        .instret   (instret)
    );

    tb_imem_model #(
        .reset_pc    (reset_pc),
        .wfi_index   (wfi_index),
        .ebreak_index(ebreak_index),
        .seed        (30904),
        .lat_min     (1),
        .lat_max     (4)
    ) imem_model_i (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_rdata(imem_rdata)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK; // 20 ns period.

    function automatic string test_name(input int idx);
        case (idx)
            0:       return "reset_state";
            1:       return "sequential_fetch";
            2:       return "retire_counting";
            3:       return "wfi_sleep_wake";
            4:       return "back_pressure";
            default: return "halt";
        endcase
    endfunction

    task automatic value_mismatch(input int idx, input logic [63:0] expected,
                                  input logic [63:0] actual);
        $display("CHECK FAILED %s expected %0h actual %0h at %0t",
                 test_name(idx), expected, actual, $time);
        fail_count[idx]++;
    endtask

    task automatic report_problem(input int idx, input string what);
        $display("ERROR in %s: %s at %0t", test_name(idx), what, $time);
        fail_count[idx]++;
    endtask

    task automatic finish_test(input int idx);
        if (fail_count[idx] == 0) begin
            $display("test %0d %s: ok", idx + 1, test_name(idx));
            passed++;
        end else begin
            $display("test %0d %s: %0d errors", idx + 1, test_name(idx), fail_count[idx]);
            failed++;
        end
    endtask

    task automatic check_reset_values();
        assert (imem_req == 1'b0) else value_mismatch(0, 0, imem_req);
        assert (wfi == 1'b0) else value_mismatch(0, 0, wfi);
        assert (halt == 1'b0) else value_mismatch(0, 0, halt);
        assert (instret == '0) else value_mismatch(0, 0, instret);
    endtask

    // bus, queue and halt checks run on every edge once reset is released.
    always @(posedge CLK) begin
        if (arst_n) begin
            in_queue = ack_count - longint'(instret);
            assert (in_queue <= depth) else value_mismatch(4, depth, in_queue);
            if (sleep_watch && in_queue == depth) begin
                assert (!imem_req) else report_problem(4, "request open with a full queue");
            end
            if (wait_pending) begin // an open request holds until its ack.
                assert (imem_req) else report_problem(1, "request dropped before its ack");
                assert (imem_addr == wait_addr) else value_mismatch(1, wait_addr, imem_addr);
            end
            if (imem_req && imem_ack) begin
                assert (imem_addr == reset_pc + addr_t'(4 * ack_count))
                    else value_mismatch(1, reset_pc + addr_t'(4 * ack_count), imem_addr);
                ack_count++;
            end
            wait_pending = imem_req && !imem_ack;
            wait_addr    = imem_addr;
            if (sleep_watch) begin
                assert (instret == sleep_base) else value_mismatch(3, sleep_base, instret);
            end
            if (halt_seen) begin // a request that started with halt itself is allowed.
                assert (halt) else report_problem(5, "halt dropped after it was set");
                assert (!(imem_req && !req_prev))
                    else report_problem(5, "new request started after halt");
            end
            halt_seen = halt_seen || halt;
            req_prev  = imem_req;
        end
    end

    initial begin
        arst_n       = 1'b0;
        soft_irq     = 1'b0;
        passed       = 0;
        failed       = 0;
        ack_count    = 0;
        in_queue     = 0;
        wait_pending = 1'b0;
        wait_addr    = '0;
        req_prev     = 1'b0;
        halt_seen    = 1'b0;
        sleep_watch  = 1'b0;
        sleep_base   = '0;
        for (int i = 0; i < num_tests; i++) begin
            fail_count[i] = 0;
        end

        repeat (3) begin
            @(posedge CLK);
            check_reset_values();
        end
        #1;
        arst_n = 1'b1;
        @(posedge CLK);
        check_reset_values(); // the first request only starts on this edge.
        finish_test(0);

        do begin
            @(posedge CLK);
        end while (!wfi);
        @(posedge CLK); // the wfi word has retired now.
        assert (instret == count_t'(wfi_index + 1))
            else value_mismatch(2, wfi_index + 1, instret);
        @(posedge CLK);
        #1;
        sleep_base  = instret;
        sleep_watch = 1'b1;
        repeat (sleep_cycles - 2) @(posedge CLK);
        #1;
        sleep_watch = 1'b0;
        soft_irq    = 1'b1; // wake the core with a two cycle pulse.
        repeat (2) @(posedge CLK);
        #1;
        soft_irq = 1'b0;

        do begin
            @(posedge CLK);
        end while (!halt);
        assert (instret == count_t'(ebreak_index + 1))
            else value_mismatch(2, ebreak_index + 1, instret);
        assert (instret > sleep_base) else value_mismatch(3, sleep_base + 1, instret);
        finish_test(2);
        finish_test(3);

        repeat (20) @(posedge CLK); // halt must hold and fetch must stay quiet.
        finish_test(1);
        finish_test(4);
        finish_test(5);

        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", max_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rvb_clk_gating.sv ====
`default_nettype none
`timescale 1ns/10ps

// core run enable. a retiring wfi turns the core off and a software
// interrupt turns it back on. the enable feeds the blocks as a clock enable
// so the core clock itself is never gated.
module rvb_clk_gating (
    input  logic CLK,
    input  logic arst_n,
    input  logic wfi,
    input  logic soft_irq,
    output logic core_clk_en
);

    logic en_q; // registered enable.

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            en_q <= 1'b1; // the core runs out of reset.
        end else if (soft_irq) begin
            en_q <= 1'b1; // interrupt wins over a wfi in the same cycle.
        end else if (wfi) begin
            en_q <= 1'b0; // drops on the edge after the wfi pulse.
        end
    end

    assign core_clk_en = en_q;

endmodule

`default_nettype wire

// ==== verilog/rvb_config.svh ====
`ifndef RVB_CONFIG_SVH
`define RVB_CONFIG_SVH

// address of the very first instruction fetch after reset.
`define RVB_RESET_PC 32'h8000_0000

// number of entries in the instruction queue between fetch and execute.
`define RVB_QUEUE_DEPTH 4

// standard base ISA encodings of the two system instructions that are decoded.
`define RVB_INSN_WFI    32'h1050_0073 // encoding taken from the privileged spec.
`define RVB_INSN_EBREAK 32'h0010_0073 // stops the core when it retires.

`endif

// ==== verilog/rvb_core.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rvb_config.svh"

// top level of the retire subsystem. fetch fills the queue from the
// instruction bus, execute drains and counts it, and the gating block
// stops and restarts both around wfi.
module rvb_core #(
    parameter rvb_pkg::addr_t reset_pc = `RVB_RESET_PC,
    parameter int             depth    = `RVB_QUEUE_DEPTH
) (
    input  logic            CLK,
    input  logic            arst_n,
    input  logic            soft_irq,
    input  logic            imem_ack,
    input  rvb_pkg::insn_t  imem_rdata,
    output logic            imem_req,
    output rvb_pkg::addr_t  imem_addr,
    output logic            wfi,
    output logic            halt,
    output rvb_pkg::count_t instret
);
    import rvb_pkg::*;

    logic  core_clk_en; // run enable shared by fetch and execute.
    logic  push;        // fetch writes a word.
    insn_t push_data;
    logic  full;        // back-pressure to fetch.
    logic  pop;         // execute takes the head word.
    insn_t pop_data;
    logic  empty;

    // wfi comes from the execute stage and clears the run enable.
    rvb_clk_gating clk_gating_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .wfi        (wfi),
        .soft_irq   (soft_irq),
        .core_clk_en(core_clk_en)
    );

    rvb_fetch_unit #(.reset_pc(reset_pc)) fetch_unit_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .core_clk_en(core_clk_en),
        .halt       (halt),        // stops fetching once ebreak retired.
        .full       (full),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .push       (push),
        .push_data  (push_data)
    );

    rvb_instr_queue #(.depth(depth)) instr_queue_i (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .pop_data (pop_data),
        .full     (full),
        .empty    (empty)
    );

    rvb_exec_unit exec_unit_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .core_clk_en(core_clk_en),
        .empty      (empty),
        .pop_data   (pop_data),
        .pop        (pop),
        .wfi        (wfi),
        .halt       (halt),
        .instret    (instret)
    );

endmodule

`default_nettype wire

// ==== verilog/rvb_exec_unit.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rvb_config.svh"

// the execute unit retires one queued word per cycle while it runs. it only
// decodes the two system instructions that change the core's run state,
// everything else simply retires and is counted.
module rvb_exec_unit (
    input  logic            CLK,
    input  logic            arst_n,
    input  logic            core_clk_en,
    input  logic            empty,
    input  rvb_pkg::insn_t  pop_data,
    output logic            pop,
    output logic            wfi,
    output logic            halt,
    output rvb_pkg::count_t instret
);
    import rvb_pkg::*;

    exec_state_e state;
    exec_state_e state_next;
    logic        is_wfi;    // head word is a wfi.
    logic        is_ebreak; // head word is an ebreak.

    assign is_wfi    = (pop_data == `RVB_INSN_WFI);
    assign is_ebreak = (pop_data == `RVB_INSN_EBREAK);

    // a word retires in the same cycle it is popped, so pop doubles as the
    // retire strobe.
    assign pop = (state == exec_run) && core_clk_en && !empty;

    // the wfi pulse leaves in the retire cycle so the gating block can drop
    // the enable on the following edge.
    assign wfi = pop && is_wfi;

    always_comb begin
        state_next = state;
        case (state)
            exec_run: begin
                if (pop && is_ebreak) begin
                    state_next = exec_halted; // ebreak still counts as retired.
                end else if (pop && is_wfi) begin
                    state_next = exec_sleep;
                end
            end
            exec_sleep: begin
                // the enable is already low here unless an interrupt arrived
                // in the wfi cycle itself, in which case the core wakes at once.
                if (core_clk_en) begin
                    state_next = exec_run;
                end
            end
            exec_halted: begin
                state_next = exec_halted; // only reset leaves this state.
            end
            default: begin
                state_next = exec_run;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= exec_run;
            instret <= '0;
        end else begin
            state <= state_next;
            if (pop) begin
                instret <= instret + count_t'(1); // one per retired word.
            end
        end
    end

    // halt comes from the state register, so it rises on the edge after the
    // ebreak retires and holds until reset.
    assign halt = (state == exec_halted);

endmodule

`default_nettype wire

// ==== verilog/rvb_fetch_unit.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rvb_config.svh"

// the fetch unit walks sequentially through instruction memory, one request
// at a time, and pushes every word it gets back into the instruction queue.
module rvb_fetch_unit #(
    parameter rvb_pkg::addr_t reset_pc = `RVB_RESET_PC
) (
    input  logic           CLK,
    input  logic           arst_n,
    input  logic           core_clk_en,
    input  logic           halt,
    input  logic           full,
    input  logic           imem_ack,
    input  rvb_pkg::insn_t imem_rdata,
    output logic           imem_req,
    output rvb_pkg::addr_t imem_addr,
    output logic           push,
    output rvb_pkg::insn_t push_data
);
    import rvb_pkg::*;

    fetch_state_e state;      // current bus phase.
    fetch_state_e state_next;
    addr_t        pc;         // address of the next word to fetch.
    logic         can_issue;  // a new request may start on the next edge.

    // gating only blocks the start of a request. a request already on the bus
    // always runs to its ack so that no word is lost while the core sleeps.
    assign can_issue = core_clk_en && !full && !halt;

    always_comb begin
        state_next = state; // hold by default.
        case (state)
            fetch_idle: begin
                if (halt) begin
                    state_next = fetch_stopped; // ebreak retired, stop for good.
                end else if (can_issue) begin
                    state_next = fetch_wait_ack;
                end
            end
            fetch_wait_ack: begin
                if (imem_ack) begin
                    state_next = fetch_idle; // req drops in the cycle after the ack.
                end
            end
            fetch_stopped: begin
                state_next = fetch_stopped;
            end
            default: begin
                state_next = fetch_idle;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= fetch_idle;
            pc    <= reset_pc; // first fetch goes to the reset vector.
        end else begin
            state <= state_next;
            if (push) begin
                pc <= pc + addr_t'(4); // there are no branches, so the pc only steps forward.
            end
        end
    end

    // the request and its address come straight from registers, so both are
    // stable for as long as the memory takes to answer.
    assign imem_req  = (state == fetch_wait_ack);
    assign imem_addr = pc;

    // the word goes into the queue in the very cycle it is acknowledged.
    // full was checked before the request, so there is always room for it.
    assign push      = (state == fetch_wait_ack) && imem_ack;
    assign push_data = imem_rdata;

endmodule

`default_nettype wire

// ==== verilog/rvb_instr_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rvb_config.svh"

// circular buffer holding fetched words until the execute unit takes them.
// a push and a pop may happen in the same cycle.
module rvb_instr_queue #(
    parameter int depth = `RVB_QUEUE_DEPTH
) (
    input  logic           CLK,
    input  logic           arst_n,
    input  logic           push,
    input  rvb_pkg::insn_t push_data,
    input  logic           pop,
    output rvb_pkg::insn_t pop_data,
    output logic           full,
    output logic           empty
);
    import rvb_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;

    localparam ptr_t last_ptr = ptr_t'(depth - 1);

    insn_t             mem [depth]; // storage for the queued words.
    ptr_t              wr_ptr;      // next free slot.
    ptr_t              rd_ptr;      // head of the queue.
    logic [cnt_w-1:0]  count;       // number of valid entries.
    logic              wr_en;
    logic              rd_en;

    // the pointers wrap by hand so that depth need not be a power of two.
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        if (ptr == last_ptr) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_en = push && !full;  // fetch never pushes when full anyway.
    assign rd_en = pop && !empty;

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0; // queue comes out of reset empty.
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the level alone.
            endcase
        end
    end

    assign pop_data = mem[rd_ptr]; // head is visible whenever empty is low.
    assign full     = (count == cnt_w'(depth));
    assign empty    = (count == '0);

endmodule

`default_nettype wire

// ==== verilog/rvb_pkg.sv ====
`default_nettype none

package rvb_pkg;

    // vector types shared by the blocks of the core.
    typedef logic [31:0] addr_t;  // byte address of an instruction.
    typedef logic [31:0] insn_t;  // one 32-bit instruction word.
    typedef logic [63:0] count_t; // minstret-style retired instruction count.

    // fetch side sequencing.
    typedef enum logic [1:0] {
        fetch_idle,     // no request on the bus.
        fetch_wait_ack, // request held until the memory acknowledges.
        fetch_stopped   // nothing more is fetched once halt was seen.
    } fetch_state_e;

    // execute side sequencing.
    typedef enum logic [1:0] {
        exec_run,   // retiring from the queue.
        exec_sleep, // a wfi retired and the enable has not come back yet.
        exec_halted // the core stays here from an ebreak until reset.
    } exec_state_e;

endpackage

`default_nettype wire
